/* all.f */
+incdir+design
design/csr_pkg.sv
design/trap_arbiter.sv
design/csr_counters.sv
design/csr_regfile.sv
design/csr_unit.sv
sim/csr_unit_assert.sv
sim/csr_unit_tb.sv

/* design/csr_consts.svh */
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

// Machine trap CSRs
`define CSR_MSTATUS   12'h300
`define CSR_MIE       12'h304
`define CSR_MTVEC     12'h305
`define CSR_MEPC      12'h341
`define CSR_MCAUSE    12'h342
`define CSR_MIP       12'h344

// Counters, machine view
`define CSR_MCYCLE    12'hB00
`define CSR_MCYCLEH   12'hB80
`define CSR_MINSTRET  12'hB02
`define CSR_MINSTRETH 12'hB82

// Counters, user view
`define CSR_CYCLE     12'hC00
`define CSR_CYCLEH    12'hC80
`define CSR_INSTRET   12'hC02
`define CSR_INSTRETH  12'hC82

`define CSR_MHARTID   12'hF14

// mip bit positions
`define MIP_MSIP_BIT  3
`define MIP_MTIP_BIT  7
`define MIP_MEIP_BIT  11

// Index into the 3-bit pending image
`define IRQ_IDX_SOFT  0
`define IRQ_IDX_TIMER 1
`define IRQ_IDX_EXT   2

// Exception and interrupt cause codes
`define CAUSE_ILLEGAL    2
`define CAUSE_BREAK      3
`define CAUSE_LOAD_FAULT 5
`define CAUSE_ECALL      11
`define CAUSE_SOFT_INT   3
`define CAUSE_TIMER_INT  7
`define CAUSE_EXT_INT    11
`define INT_FLAG         31

`endif

/* design/csr_counters.sv */
`timescale 1ns/1ps

module csr_counters (
  input  logic        clock,
  input  logic        reset,
  input  logic        stall,
  output logic [63:0] cycle_count,
  output logic [63:0] instret_count
);

  // Free running, one per edge
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      cycle_count <= 64'h0;
    end else begin
      cycle_count <= cycle_count + 64'h1;
    end
  end

  // Retired instructions, paused while the pipe is stalled
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      instret_count <= 64'h0;
    end else if (!stall) begin
      instret_count <= instret_count + 64'h1;
    end
  end

endmodule

/* design/csr_pkg.sv */
package csr_pkg;

  // Machine status word, only the interrupt enable pair is implemented
  typedef struct packed {
    logic [31:8] rsvd_31_8;
    logic        mpie;         // Previous MIE, saved on trap entry
    logic [6:4]  rsvd_6_4;
    logic        mie;          // Global machine interrupt enable
    logic [2:0]  rsvd_2_0;
  } mstatus_t;

  // Per-source interrupt enables, same bit positions as mip
  typedef struct packed {
    logic [31:12] rsvd_31_12;
    logic         meie;        // External
    logic [10:8]  rsvd_10_8;
    logic         mtie;        // Timer
    logic [6:4]   rsvd_6_4;
    logic         msie;        // Software
    logic [2:0]   rsvd_2_0;
  } mie_t;

  // One CSR word seen either as mstatus or as mie fields
  typedef union packed {
    logic [31:0] raw;
    mstatus_t    status;
    mie_t        enables;
  } csr_word_u;

endpackage

/* design/csr_regfile.sv */
`timescale 1ns/1ps
`include "csr_consts.svh"

module csr_regfile
  import csr_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  logic        csr_write,
  input  logic [11:0] csr_addr,
  input  logic [31:0] csr_wdata,
  input  logic        mret,
  input  logic [31:0] pc,
  input  logic        trap_take,
  input  logic [31:0] trap_cause,
  input  logic [2:0]  irq_pending,
  input  logic [63:0] cycle_count,
  input  logic [63:0] instret_count,
  output logic [31:0] csr_rdata,
  output logic [31:0] mtvec,
  output logic [31:0] mepc,
  output csr_word_u   mstatus_word,
  output csr_word_u   mie_word,
  output logic        redirect
);

  csr_word_u   mstatus_q;
  csr_word_u   mie_q;
  logic [31:0] mtvec_q;
  logic [31:0] mepc_q;
  logic [31:0] mcause_q;

  csr_word_u   wr_word;
  csr_word_u   status_wr;
  csr_word_u   enables_wr;
  logic [31:0] mip_value;
  logic        wr_en;
  logic        mret_take;

  assign wr_word   = csr_wdata;
  assign wr_en     = csr_write & ~trap_take; // Trap drops the write
  assign mret_take = mret & ~trap_take;
  assign redirect  = trap_take | mret_take;

  // Keep only the implemented fields of each write
  always_comb begin
    status_wr                  = '0;
    status_wr.status.mie       = wr_word.status.mie;
    status_wr.status.mpie      = wr_word.status.mpie;
    enables_wr                 = '0;
    enables_wr.enables.msie    = wr_word.enables.msie;
    enables_wr.enables.mtie    = wr_word.enables.mtie;
    enables_wr.enables.meie    = wr_word.enables.meie;
  end

  always_comb begin
    mip_value                = 32'h0;
    mip_value[`MIP_MSIP_BIT] = irq_pending[`IRQ_IDX_SOFT];
    mip_value[`MIP_MTIP_BIT] = irq_pending[`IRQ_IDX_TIMER];
    mip_value[`MIP_MEIP_BIT] = irq_pending[`IRQ_IDX_EXT];
  end

  always_comb begin
    case (csr_addr)
      `CSR_MSTATUS:                csr_rdata = mstatus_q.raw;
      `CSR_MIE:                    csr_rdata = mie_q.raw;
      `CSR_MTVEC:                  csr_rdata = mtvec_q;
      `CSR_MEPC:                   csr_rdata = mepc_q;
      `CSR_MCAUSE:                 csr_rdata = mcause_q;
      `CSR_MIP:                    csr_rdata = mip_value;
      `CSR_MCYCLE, `CSR_CYCLE:     csr_rdata = cycle_count[31:0];
      `CSR_MCYCLEH, `CSR_CYCLEH:   csr_rdata = cycle_count[63:32];
      `CSR_MINSTRET, `CSR_INSTRET: csr_rdata = instret_count[31:0];
      `CSR_MINSTRETH, `CSR_INSTRETH: csr_rdata = instret_count[63:32];
      `CSR_MHARTID:                csr_rdata = 32'h0; // Single hart
      default:                     csr_rdata = 32'h0;
    endcase
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      mstatus_q <= '0;
      mie_q     <= '0;
      mtvec_q   <= 32'h0;
      mepc_q    <= 32'h0;
      mcause_q  <= 32'h0;
    end else begin
      if (wr_en) begin
        case (csr_addr)
          `CSR_MSTATUS: mstatus_q <= status_wr;
          `CSR_MIE:     mie_q     <= enables_wr;
          `CSR_MTVEC:   mtvec_q   <= csr_wdata;
          `CSR_MEPC:    mepc_q    <= csr_wdata;
          `CSR_MCAUSE:  mcause_q  <= csr_wdata;
          default: ;                             // Read-only or unmapped
        endcase
      end
      if (trap_take) begin
        mepc_q                <= pc;
        mcause_q              <= trap_cause;
        mstatus_q.status.mpie <= mstatus_q.status.mie;
        mstatus_q.status.mie  <= 1'b0;
      end else if (mret_take) begin
        mstatus_q.status.mie  <= mstatus_q.status.mpie;
        mstatus_q.status.mpie <= 1'b1;
      end
    end
  end

  assign mtvec        = mtvec_q;
  assign mepc         = mepc_q;
  assign mstatus_word = mstatus_q;
  assign mie_word     = mie_q;

endmodule

/* design/csr_unit.sv */
`timescale 1ns/1ps

module csr_unit
  import csr_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  logic        stall,
  input  logic        csr_write,
  input  logic [11:0] csr_addr,
  input  logic [31:0] csr_wdata,
  input  logic        mret,
  input  logic [31:0] pc,
  input  logic        illegal_instr,
  input  logic        env_call,
  input  logic        load_fault,
  input  logic        break_point,
  input  logic        timer_int,
  input  logic        soft_int,
  input  logic        ext_int,
  output logic [31:0] csr_rdata,
  output logic [31:0] mtvec,
  output logic [31:0] mepc,
  output logic        redirect
);

  csr_word_u   mstatus_word;
  csr_word_u   mie_word;
  logic        trap_take;
  logic [31:0] trap_cause;
  logic [2:0]  irq_pending;
  logic [63:0] cycle_count;
  logic [63:0] instret_count;

  trap_arbiter trap_arbiter_inst (
    .illegal_instr (illegal_instr),
    .env_call      (env_call),
    .load_fault    (load_fault),
    .break_point   (break_point),
    .timer_int     (timer_int),
    .soft_int      (soft_int),
    .ext_int       (ext_int),
    .mstatus_word  (mstatus_word),
    .mie_word      (mie_word),
    .trap_take     (trap_take),
    .trap_cause    (trap_cause),
    .irq_pending   (irq_pending)
  );

  csr_counters csr_counters_inst (
    .clock         (clock),
    .reset         (reset),
    .stall         (stall),
    .cycle_count   (cycle_count),
    .instret_count (instret_count)
  );

  csr_regfile csr_regfile_inst (
    .clock         (clock),
    .reset         (reset),
    .csr_write     (csr_write),
    .csr_addr      (csr_addr),
    .csr_wdata     (csr_wdata),
    .mret          (mret),
    .pc            (pc),
    .trap_take     (trap_take),
    .trap_cause    (trap_cause),
    .irq_pending   (irq_pending),
    .cycle_count   (cycle_count),
    .instret_count (instret_count),
    .csr_rdata     (csr_rdata),
    .mtvec         (mtvec),
    .mepc          (mepc),
    .mstatus_word  (mstatus_word),
    .mie_word      (mie_word),
    .redirect      (redirect)
  );

endmodule

/* design/trap_arbiter.sv */
`timescale 1ns/1ps
`include "csr_consts.svh"

module trap_arbiter
  import csr_pkg::*;
(
  input  logic        illegal_instr,
  input  logic        env_call,
  input  logic        load_fault,
  input  logic        break_point,
  input  logic        timer_int,
  input  logic        soft_int,
  input  logic        ext_int,
  input  csr_word_u   mstatus_word,
  input  csr_word_u   mie_word,
  output logic        trap_take,
  output logic [31:0] trap_cause,
  output logic [2:0]  irq_pending
);

  logic any_exception;
  logic global_en;
  logic timer_fire;
  logic soft_fire;
  logic ext_fire;
  logic any_irq;

  assign any_exception = illegal_instr | env_call | load_fault | break_point;
  assign global_en     = mstatus_word.status.mie;

  // Interrupt needs both the global and its own enable
  assign timer_fire = timer_int & mie_word.enables.mtie & global_en;
  assign soft_fire  = soft_int & mie_word.enables.msie & global_en;
  assign ext_fire   = ext_int & mie_word.enables.meie & global_en;
  assign any_irq    = timer_fire | soft_fire | ext_fire;

  assign trap_take = any_exception | any_irq; // Exceptions ignore MIE

  always_comb begin
    trap_cause = 32'h0;
    if (any_exception) begin
      if (break_point) begin
        trap_cause = 32'(`CAUSE_BREAK);
      end else if (load_fault) begin
        trap_cause = 32'(`CAUSE_LOAD_FAULT);
      end else if (illegal_instr) begin
        trap_cause = 32'(`CAUSE_ILLEGAL);
      end else begin
        trap_cause = 32'(`CAUSE_ECALL);
      end
    end else if (any_irq) begin
      if (timer_fire) begin
        trap_cause = 32'(`CAUSE_TIMER_INT);
      end else if (soft_fire) begin
        trap_cause = 32'(`CAUSE_SOFT_INT);
      end else begin
        trap_cause = 32'(`CAUSE_EXT_INT);
      end
      trap_cause[`INT_FLAG] = 1'b1; // Interrupt marker
    end
  end

  // Raw pending lines, before any masking
  always_comb begin
    irq_pending                 = 3'b000;
    irq_pending[`IRQ_IDX_SOFT]  = soft_int;
    irq_pending[`IRQ_IDX_TIMER] = timer_int;
    irq_pending[`IRQ_IDX_EXT]   = ext_int;
  end

endmodule

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module csr_unit_tb \
  --Mdir obj_dir -o csr_unit_sim

./obj_dir/csr_unit_sim

/* sim/csr_unit_assert.sv */
`timescale 1ns/1ps

module csr_unit_assert
  import csr_pkg::*;
(
  input logic      clock,
  input logic      reset,
  input logic      redirect,
  input logic      trap_take,
  input logic      mret,
  input logic      illegal_instr,
  input logic      env_call,
  input logic      load_fault,
  input logic      break_point,
  input logic      timer_int,
  input logic      soft_int,
  input logic      ext_int,
  input csr_word_u mstatus_word
);

  // Redirect needs an mret or at least one trap source at the pins
  redirect_has_source: assert property (
    @(posedge clock) disable iff (reset)
      redirect |-> (mret || illegal_instr || env_call || load_fault || break_point ||
                    timer_int || soft_int || ext_int)
  ) else $error("redirect high without a trap source or an mret");

  // Trap entry drops the global enable
  trap_clears_mie: assert property (
    @(posedge clock) disable iff (reset) trap_take |=> !mstatus_word.status.mie
  ) else $error("mstatus.mie still set after a trap");

  redirect_low_after_reset: assert property (
    @(posedge clock) $fell(reset) |-> !redirect
  ) else $error("redirect high right after reset release");

endmodule

bind csr_unit csr_unit_assert csr_unit_assert_inst (
  .clock         (clock),
  .reset         (reset),
  .redirect      (redirect),
  .trap_take     (trap_take),
  .mret          (mret),
  .illegal_instr (illegal_instr),
  .env_call      (env_call),
  .load_fault    (load_fault),
  .break_point   (break_point),
  .timer_int     (timer_int),
  .soft_int      (soft_int),
  .ext_int       (ext_int),
  .mstatus_word  (mstatus_word)
);

/* sim/csr_unit_tb.sv */
`timescale 1ns/1ps
`include "csr_consts.svh"

module csr_unit_tb;

  typedef enum logic [2:0] {OP_IDLE, OP_WRITE, OP_READ, OP_TRAP, OP_MRET} op_e;

  typedef struct {
    op_e         op;
    logic [11:0] addr;
    logic [31:0] data;
    logic [31:0] pc;
    logic [6:0]  flags;         // {ext, soft, timer, break, load, illegal, ecall}
    logic [31:0] exp_rdata;
    logic        exp_redirect;
  } row_t;

  localparam logic [6:0]  F_ECALL     = 7'b000_0001;
  localparam logic [6:0]  F_ILLEGAL   = 7'b000_0010;
  localparam logic [6:0]  F_LOAD      = 7'b000_0100;
  localparam logic [6:0]  F_BREAK     = 7'b000_1000;
  localparam logic [6:0]  F_TIMER     = 7'b001_0000;
  localparam logic [6:0]  F_SOFT      = 7'b010_0000;
  localparam logic [6:0]  F_EXT       = 7'b100_0000;
  localparam logic [31:0] STATUS_MIE  = 32'h0000_0008;
  localparam logic [31:0] STATUS_MPIE = 32'h0000_0080;
  localparam logic [31:0] STATUS_MASK = 32'h0000_0088;
  localparam logic [31:0] MIE_MASK    = 32'h0000_0888;
  localparam logic [31:0] MIE_MEIE    = 32'h0000_0800;
  localparam logic [31:0] INT_BIT     = 32'h8000_0000;
  localparam int          RESET_TIMEOUT = 100;
  localparam int          CYCLE_GAP     = 37;
  localparam int          INSTRET_GAP   = 40;

  logic        clock;
  logic        reset;
  logic        stall;
  logic        csr_write;
  logic [11:0] csr_addr;
  logic [31:0] csr_wdata;
  logic        mret;
  logic [31:0] pc;
  logic        illegal_instr;
  logic        env_call;
  logic        load_fault;
  logic        break_point;
  logic        timer_int;
  logic        soft_int;
  logic        ext_int;
  logic [31:0] csr_rdata;
  logic [31:0] mtvec;
  logic [31:0] mepc;
  logic        redirect;

  row_t        rows[$];
  logic [31:0] mtvec_val;
  logic [31:0] last_trap_pc;

  csr_unit csr_unit_inst (.*);

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  initial begin
    reset = 1'b1;
    repeat (10) @(negedge clock);
    reset = 1'b0;
  end

  task automatic stop_on_error();
    $display("TESTS FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    while (reset !== 1'b0) begin
      @(negedge clock);
      cycles++;
      if (cycles > RESET_TIMEOUT) begin
        $display("timeout: reset still high after %0d cycles", RESET_TIMEOUT);
        stop_on_error();
      end
    end
  endtask

  task automatic add_row(input op_e op, input logic [11:0] addr, input logic [31:0] data,
                         input logic [31:0] row_pc, input logic [6:0] flags,
                         input logic [31:0] exp_rdata, input logic exp_redirect);
    row_t r;
    r.op           = op;
    r.addr         = addr;
    r.data         = data;
    r.pc           = row_pc;
    r.flags        = flags;
    r.exp_rdata    = exp_rdata;
    r.exp_redirect = exp_redirect;
    rows.push_back(r);
  endtask

  task automatic add_write(input logic [11:0] addr, input logic [31:0] data);
    add_row(OP_WRITE, addr, data, 32'h0, 7'h0, 32'h0, 1'b0);
  endtask

  task automatic add_read(input logic [11:0] addr, input logic [31:0] exp_rdata);
    add_row(OP_READ, addr, 32'h0, 32'h0, 7'h0, exp_rdata, 1'b0);
  endtask

  task automatic add_trap(input logic [6:0] flags, input logic [31:0] row_pc, input logic taken);
    add_row(OP_TRAP, 12'h0, 32'h0, row_pc, flags, 32'h0, taken);
  endtask

  // Trap that must be taken, then mcause and mepc readback
  task automatic add_taken_trap(input logic [6:0] flags, input logic [31:0] cause);
    logic [31:0] p;
    p = $urandom();
    add_trap(flags, p, 1'b1);
    add_read(`CSR_MCAUSE, cause);
    add_read(`CSR_MEPC, p);
  endtask

  task automatic add_single_irq(input logic [6:0] flags, input logic [31:0] cause);
    add_write(`CSR_MCAUSE, 32'h0);
    add_write(`CSR_MSTATUS, STATUS_MIE);
    add_taken_trap(flags, INT_BIT | cause);
    add_read(`CSR_MSTATUS, STATUS_MPIE);
  endtask

  task automatic build_table();
    logic [31:0] w;
    logic [31:0] p;
    add_read(`CSR_MSTATUS, 32'h0);
    mtvec_val = $urandom();
    add_write(`CSR_MTVEC, mtvec_val);
    add_read(`CSR_MTVEC, mtvec_val);
    w = $urandom();
    add_write(`CSR_MEPC, w);
    add_read(`CSR_MEPC, w);
    w = $urandom();
    add_write(`CSR_MIE, w);
    add_read(`CSR_MIE, w & MIE_MASK);
    w = $urandom() & ~STATUS_MIE;
    add_write(`CSR_MSTATUS, w);
    add_read(`CSR_MSTATUS, w & STATUS_MASK);
    add_write(`CSR_MIP, $urandom());
    add_read(`CSR_MIP, 32'h0);
    add_write(`CSR_MHARTID, $urandom());
    add_read(`CSR_MHARTID, 32'h0);
    add_write(12'h7C0, $urandom());
    add_read(12'h7C0, 32'h0);
    // mip shows raw lines, global enable is clear so no trap
    add_row(OP_READ, `CSR_MIP, 32'h0, 32'h0, F_TIMER | F_SOFT | F_EXT, 32'h888, 1'b0);
    add_write(`CSR_MIE, MIE_MASK);
    add_write(`CSR_MSTATUS, 32'h0);
    add_trap(F_TIMER, $urandom(), 1'b0);
    add_read(`CSR_MCAUSE, 32'h0);
    add_write(`CSR_MSTATUS, STATUS_MIE);
    add_write(`CSR_MIE, MIE_MEIE);
    add_trap(F_TIMER, $urandom(), 1'b0);                // Own enable clear
    add_read(`CSR_MCAUSE, 32'h0);
    add_write(`CSR_MIE, MIE_MASK);
    add_taken_trap(F_TIMER | F_SOFT | F_EXT, INT_BIT | 32'd`CAUSE_TIMER_INT);
    add_read(`CSR_MSTATUS, STATUS_MPIE);
    add_single_irq(F_SOFT, 32'd`CAUSE_SOFT_INT);
    add_single_irq(F_EXT, 32'd`CAUSE_EXT_INT);
    add_single_irq(F_TIMER, 32'd`CAUSE_TIMER_INT);
    // Exceptions with MIE clear
    add_taken_trap(F_ECALL, 32'd`CAUSE_ECALL);
    add_taken_trap(F_ILLEGAL, 32'd`CAUSE_ILLEGAL);
    add_taken_trap(F_LOAD, 32'd`CAUSE_LOAD_FAULT);
    add_taken_trap(F_BREAK, 32'd`CAUSE_BREAK);
    add_taken_trap(F_BREAK | F_LOAD | F_ILLEGAL | F_ECALL, 32'd`CAUSE_BREAK);
    add_taken_trap(F_LOAD | F_ILLEGAL | F_ECALL, 32'd`CAUSE_LOAD_FAULT);
    add_taken_trap(F_ILLEGAL | F_ECALL, 32'd`CAUSE_ILLEGAL);
    add_read(`CSR_MSTATUS, 32'h0);
    add_write(`CSR_MSTATUS, STATUS_MIE);
    add_taken_trap(F_ECALL | F_TIMER | F_EXT, 32'd`CAUSE_ECALL);
    add_read(`CSR_MSTATUS, STATUS_MPIE);
    add_row(OP_WRITE, `CSR_MTVEC, $urandom(), $urandom(), F_ILLEGAL, 32'h0, 1'b1);
    add_read(`CSR_MTVEC, mtvec_val);                      // Write was dropped
    add_read(`CSR_MCAUSE, 32'd`CAUSE_ILLEGAL);
    // mret sequence, MPIE and MIE both clear here
    add_row(OP_MRET, 12'h0, 32'h0, 32'h0, 7'h0, 32'h0, 1'b1);
    add_read(`CSR_MSTATUS, STATUS_MPIE);
    add_row(OP_MRET, 12'h0, 32'h0, 32'h0, 7'h0, 32'h0, 1'b1);
    add_read(`CSR_MSTATUS, STATUS_MIE | STATUS_MPIE);
    p = $urandom();
    last_trap_pc = p;
    add_row(OP_MRET, 12'h0, 32'h0, p, F_ECALL, 32'h0, 1'b1); // Trap wins over mret
    add_read(`CSR_MSTATUS, STATUS_MPIE);
    add_read(`CSR_MCAUSE, 32'd`CAUSE_ECALL);
    add_read(`CSR_MEPC, p);
    add_row(OP_MRET, 12'h0, 32'h0, 32'h0, 7'h0, 32'h0, 1'b1);
    add_read(`CSR_MSTATUS, STATUS_MIE | STATUS_MPIE);
    add_row(OP_IDLE, 12'h0, 32'h0, 32'h0, 7'h0, 32'h0, 1'b0);
  endtask

  task automatic apply_row(input row_t r, input int idx);
    @(negedge clock);
    csr_write = (r.op == OP_WRITE);
    mret      = (r.op == OP_MRET);
    csr_addr  = r.addr;
    csr_wdata = r.data;
    pc        = r.pc;
    {ext_int, soft_int, timer_int, break_point, load_fault, illegal_instr, env_call} = r.flags;
    #1;
    check_value($sformatf("redirect (row %0d)", idx), 64'(redirect), 64'(r.exp_redirect));
    if (r.op == OP_READ) begin
      check_value($sformatf("csr_rdata (row %0d)", idx), 64'(csr_rdata), 64'(r.exp_rdata));
    end
  endtask

  // Both halves in the same low phase, no edge in between
  task automatic read_counter(input logic [11:0] addr_lo, input logic [11:0] addr_hi,
                              output logic [63:0] value);
    csr_addr = addr_lo;
    #1;
    value[31:0] = csr_rdata;
    csr_addr = addr_hi;
    #1;
    value[63:32] = csr_rdata;
  endtask

  task automatic check_counters();
    logic [63:0] first;
    logic [63:0] second;
    logic [63:0] user_view;
    int          stall_count;
    @(negedge clock);
    read_counter(`CSR_MCYCLE, `CSR_MCYCLEH, first);
    read_counter(`CSR_CYCLE, `CSR_CYCLEH, user_view);
    check_value("cycle", user_view, first);
    repeat (CYCLE_GAP) @(negedge clock);
    read_counter(`CSR_MCYCLE, `CSR_MCYCLEH, second);
    check_value("mcycle delta", second - first, 64'(CYCLE_GAP));
    read_counter(`CSR_MINSTRET, `CSR_MINSTRETH, first);
    stall_count = 0;
    for (int k = 0; k < INSTRET_GAP; k++) begin
      stall = 1'($urandom_range(1, 0));
      if (stall) stall_count++;
      @(negedge clock);
    end
    stall = 1'b0;
    read_counter(`CSR_MINSTRET, `CSR_MINSTRETH, second);
    check_value("minstret delta", second - first, 64'(INSTRET_GAP - stall_count));
  endtask

  initial begin
    void'($urandom(32'h7e86f34e));
    stall         = 1'b0;
    csr_write     = 1'b0;
    csr_addr      = 12'h0;
    csr_wdata     = 32'h0;
    mret          = 1'b0;
    pc            = 32'h0;
    illegal_instr = 1'b0;
    env_call      = 1'b0;
    load_fault    = 1'b0;
    break_point   = 1'b0;
    timer_int     = 1'b0;
    soft_int      = 1'b0;
    ext_int       = 1'b0;
    wait_reset_release();
    build_table();
    foreach (rows[i]) begin
      apply_row(rows[i], i);
    end
    check_value("mtvec", 64'(mtvec), 64'(mtvec_val));
    check_value("mepc", 64'(mepc), 64'(last_trap_pc));    // mret leaves mepc alone
    check_counters();
    $display("TESTS PASSED");
    $finish;
  end

endmodule
